/* common/tile_config.svh */
// Tile geometry, data widths and TCDM address map macros
`ifndef TILE_CONFIG_SVH
`define TILE_CONFIG_SVH

// Tile geometry
`define TILE_NUM_CORES 4
`define TILE_NUM_BANKS 4
`define TILE_NUM_TILES 4
`define TILE_BANK_WORDS 256

// Datapath widths
`define TILE_DATA_WIDTH 32
`define TILE_ADDR_WIDTH 32
`define TILE_BYTE_OFFSET 2

// Shared TCDM region, word-interleaved over all banks of all tiles
`define TILE_TCDM_BASE 32'h0000_0000
`define TILE_TCDM_SIZE \
  (`TILE_NUM_TILES * `TILE_NUM_BANKS * `TILE_BANK_WORDS * (`TILE_DATA_WIDTH / 8))

`endif

/* common/tile_pkg.sv */
// Shared tile types: index, address and data types, request target and SoC FSM states
`default_nettype none

`include "tile_config.svh"

package tile_pkg;

  // Address and data
  typedef logic [`TILE_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`TILE_DATA_WIDTH-1:0]   data_t;
  typedef logic [`TILE_DATA_WIDTH/8-1:0] strb_t;

  // Indices
  typedef logic [$clog2(`TILE_NUM_CORES)-1:0] core_id_t;
  typedef logic [$clog2(`TILE_NUM_BANKS)-1:0] bank_id_t;
  typedef logic [$clog2(`TILE_NUM_TILES)-1:0] tile_id_t;

  // Word row inside one bank
  typedef logic [$clog2(`TILE_BANK_WORDS)-1:0] bank_row_t;

  // Where a core request is sent
  typedef enum logic {
    TGT_LOCAL,
    TGT_SOC
  } target_e;

  // SoC port sharing FSM
  typedef enum logic [1:0] {
    SOC_IDLE,
    SOC_REQ,
    SOC_WAIT
  } soc_state_e;

endpackage : tile_pkg

`default_nettype wire

/* source/rr_arbiter.sv */
// Round-robin arbiter with a rotating priority pointer
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module rr_arbiter #(
  parameter int unsigned NumReq = `TILE_NUM_CORES
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic [NumReq-1:0]  req_i,
  output logic               gnt_valid_o,
  output tile_pkg::core_id_t gnt_idx_o,
  input  logic               advance_i
);
  import tile_pkg::*;

  // Highest priority requester
  core_id_t ptr_q;

  // First requester at or after the pointer wins
  always_comb begin
    int unsigned cand;
    gnt_valid_o = 1'b0;
    gnt_idx_o   = ptr_q;
    for (int unsigned i = 0; i < NumReq; i++) begin
      cand = (ptr_q + i) % NumReq;
      if (!gnt_valid_o && req_i[cand]) begin
        gnt_valid_o = 1'b1;
        gnt_idx_o   = core_id_t'(cand);
      end
    end
  end

  // Rotate past the last winner
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (advance_i && gnt_valid_o) begin
      ptr_q <= core_id_t'((gnt_idx_o + 32'd1) % NumReq);
    end
  end

endmodule : rr_arbiter

`default_nettype wire

/* banks/tcdm_bank.sv */
// Byte-enabled single-port SRAM bank with registered response and core index
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module tcdm_bank (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  tile_pkg::bank_row_t row_i,
  input  tile_pkg::data_t     wdata_i,
  input  tile_pkg::strb_t     be_i,
  input  tile_pkg::core_id_t  core_i,
  output logic                resp_valid_o,
  output tile_pkg::data_t     rdata_o,
  output tile_pkg::core_id_t  core_o
);
  import tile_pkg::*;

  data_t    mem [`TILE_BANK_WORDS];
  data_t    rdata_q;
  core_id_t core_q;
  logic     valid_q;

  // Array access, a write answers with zero data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < `TILE_DATA_WIDTH / 8; b++) begin
          if (be_i[b]) begin
            mem[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[row_i];
      end
      core_q <= core_i;
    end
  end

  // One response per request, next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i;
    end
  end

  assign resp_valid_o = valid_q;
  assign rdata_o      = rdata_q;
  assign core_o       = core_q;

endmodule : tcdm_bank

`default_nettype wire

/* banks/bank_xbar.sv */
// Core to bank crossbar with per-bank round-robin arbitration and response routing
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module bank_xbar (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  // Core requests
  input  logic            [`TILE_NUM_CORES-1:0]    req_valid_i,
  output logic            [`TILE_NUM_CORES-1:0]    req_ready_o,
  input  tile_pkg::addr_t [`TILE_NUM_CORES-1:0]    req_addr_i,
  input  logic            [`TILE_NUM_CORES-1:0]    req_write_i,
  input  tile_pkg::data_t [`TILE_NUM_CORES-1:0]    req_wdata_i,
  input  tile_pkg::strb_t [`TILE_NUM_CORES-1:0]    req_be_i,
  // Core responses
  output logic            [`TILE_NUM_CORES-1:0]    resp_valid_o,
  output tile_pkg::data_t [`TILE_NUM_CORES-1:0]    resp_rdata_o
);
  import tile_pkg::*;

  localparam int unsigned BankLsb = `TILE_BYTE_OFFSET;
  localparam int unsigned RowLsb  = BankLsb + $bits(bank_id_t) + $bits(tile_id_t);

  bank_id_t  [`TILE_NUM_CORES-1:0] bank_sel;
  bank_row_t [`TILE_NUM_CORES-1:0] bank_row;

  logic     [`TILE_NUM_BANKS-1:0][`TILE_NUM_CORES-1:0] bank_req_vec;
  logic     [`TILE_NUM_BANKS-1:0] gnt_valid;
  core_id_t [`TILE_NUM_BANKS-1:0] gnt_idx;
  logic     [`TILE_NUM_BANKS-1:0] bank_resp_valid;
  data_t    [`TILE_NUM_BANKS-1:0] bank_resp_rdata;
  core_id_t [`TILE_NUM_BANKS-1:0] bank_resp_core;

  // Tile bits are skipped, the shim already matched them
  for (genvar c = 0; c < `TILE_NUM_CORES; c++) begin : gen_addr
    assign bank_sel[c] = req_addr_i[c][BankLsb +: $bits(bank_id_t)];
    assign bank_row[c] = req_addr_i[c][RowLsb +: $bits(bank_row_t)];
  end

  for (genvar b = 0; b < `TILE_NUM_BANKS; b++) begin : gen_banks
    for (genvar c = 0; c < `TILE_NUM_CORES; c++) begin : gen_req_vec
      assign bank_req_vec[b][c] = req_valid_i[c] && (bank_sel[c] == bank_id_t'(b));
    end

    // Bank never stalls, so every grant advances the pointer
    rr_arbiter #(
      .NumReq(`TILE_NUM_CORES)
    ) i_arbiter (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .req_i      (bank_req_vec[b]),
      .gnt_valid_o(gnt_valid[b]),
      .gnt_idx_o  (gnt_idx[b]),
      .advance_i  (gnt_valid[b])
    );

    tcdm_bank i_bank (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_i       (gnt_valid[b]),
      .we_i        (req_write_i[gnt_idx[b]]),
      .row_i       (bank_row[gnt_idx[b]]),
      .wdata_i     (req_wdata_i[gnt_idx[b]]),
      .be_i        (req_be_i[gnt_idx[b]]),
      .core_i      (gnt_idx[b]),
      .resp_valid_o(bank_resp_valid[b]),
      .rdata_o     (bank_resp_rdata[b]),
      .core_o      (bank_resp_core[b])
    );
  end

  // Ready to winners, responses back by returned core index
  always_comb begin
    req_ready_o  = '0;
    resp_valid_o = '0;
    resp_rdata_o = '0;
    for (int unsigned b = 0; b < `TILE_NUM_BANKS; b++) begin
      if (gnt_valid[b]) begin
        req_ready_o[gnt_idx[b]] = 1'b1;
      end
      if (bank_resp_valid[b]) begin
        resp_valid_o[bank_resp_core[b]] = 1'b1;
        resp_rdata_o[bank_resp_core[b]] = bank_resp_rdata[b];
      end
    end
  end

endmodule : bank_xbar

`default_nettype wire

/* source/tcdm_shim.sv */
// Per-core request classification, steering, response merge and SoC pending tracking
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module tcdm_shim (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  tile_pkg::tile_id_t tile_id_i,
  // Core request
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  tile_pkg::addr_t    req_addr_i,
  input  logic               req_write_i,
  input  tile_pkg::data_t    req_wdata_i,
  input  tile_pkg::strb_t    req_be_i,
  // Core response
  output logic               resp_valid_o,
  output tile_pkg::data_t    resp_rdata_o,
  // Request fields shared by both targets
  output tile_pkg::addr_t    fwd_addr_o,
  output logic               fwd_write_o,
  output tile_pkg::data_t    fwd_wdata_o,
  output tile_pkg::strb_t    fwd_be_o,
  // Bank side
  output logic               bank_valid_o,
  input  logic               bank_ready_i,
  input  logic               bank_resp_valid_i,
  input  tile_pkg::data_t    bank_resp_rdata_i,
  // SoC side
  output logic               soc_valid_o,
  input  logic               soc_ready_i,
  input  logic               soc_resp_valid_i,
  input  tile_pkg::data_t    soc_resp_rdata_i
);
  import tile_pkg::*;

  localparam addr_t       TcdmMask = ~(addr_t'(`TILE_TCDM_SIZE) - addr_t'(1));
  localparam int unsigned TileLsb  = `TILE_BYTE_OFFSET + $bits(bank_id_t);

  target_e target;
  logic    pending_q;

  // Local only when inside the TCDM and in this tile's slice
  always_comb begin
    target = TGT_SOC;
    if (((req_addr_i & TcdmMask) == `TILE_TCDM_BASE) &&
        (req_addr_i[TileLsb +: $bits(tile_id_t)] == tile_id_i)) begin
      target = TGT_LOCAL;
    end
  end

  // Nothing leaves the core while a SoC access is outstanding
  assign bank_valid_o = req_valid_i && !pending_q && (target == TGT_LOCAL);
  assign soc_valid_o  = req_valid_i && !pending_q && (target == TGT_SOC);
  assign req_ready_o  = !pending_q && ((target == TGT_LOCAL) ? bank_ready_i : soc_ready_i);

  assign fwd_addr_o  = req_addr_i;
  assign fwd_write_o = req_write_i;
  assign fwd_wdata_o = req_wdata_i;
  assign fwd_be_o    = req_be_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
    end else if (soc_resp_valid_i) begin
      pending_q <= 1'b0;
    end else if (soc_valid_o && soc_ready_i) begin
      pending_q <= 1'b1;
    end
  end

  // Both sources never answer in the same cycle
  assign resp_valid_o = bank_resp_valid_i || soc_resp_valid_i;
  assign resp_rdata_o = soc_resp_valid_i ? soc_resp_rdata_i : bank_resp_rdata_i;

endmodule : tcdm_shim

`default_nettype wire

/* source/soc_demux_fsm.sv */
// FSM sharing the single SoC port among the cores, one request outstanding
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module soc_demux_fsm (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // Core side
  input  logic            [`TILE_NUM_CORES-1:0] req_valid_i,
  output logic            [`TILE_NUM_CORES-1:0] req_ready_o,
  input  tile_pkg::addr_t [`TILE_NUM_CORES-1:0] req_addr_i,
  input  logic            [`TILE_NUM_CORES-1:0] req_write_i,
  input  tile_pkg::data_t [`TILE_NUM_CORES-1:0] req_wdata_i,
  input  tile_pkg::strb_t [`TILE_NUM_CORES-1:0] req_be_i,
  output logic            [`TILE_NUM_CORES-1:0] resp_valid_o,
  output tile_pkg::data_t [`TILE_NUM_CORES-1:0] resp_rdata_o,
  // SoC port
  output logic                                  soc_req_valid_o,
  input  logic                                  soc_req_ready_i,
  output tile_pkg::addr_t                       soc_req_addr_o,
  output logic                                  soc_req_write_o,
  output tile_pkg::data_t                       soc_req_wdata_o,
  output tile_pkg::strb_t                       soc_req_be_o,
  input  logic                                  soc_resp_valid_i,
  input  tile_pkg::data_t                       soc_resp_rdata_i
);
  import tile_pkg::*;

  soc_state_e state_q, state_d;
  logic       gnt_valid;
  core_id_t   gnt_idx;
  logic       accept;

  // Captured request and its owner
  core_id_t core_q;
  addr_t    addr_q;
  logic     write_q;
  data_t    wdata_q;
  strb_t    be_q;

  assign accept = (state_q == SOC_IDLE) && gnt_valid;

  rr_arbiter #(
    .NumReq(`TILE_NUM_CORES)
  ) i_arbiter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (req_valid_i),
    .gnt_valid_o(gnt_valid),
    .gnt_idx_o  (gnt_idx),
    .advance_i  (accept)
  );

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      SOC_IDLE: if (gnt_valid)        state_d = SOC_REQ;
      SOC_REQ:  if (soc_req_ready_i)  state_d = SOC_WAIT;
      SOC_WAIT: if (soc_resp_valid_i) state_d = SOC_IDLE;
      default:                        state_d = SOC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SOC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      core_q  <= gnt_idx;
      addr_q  <= req_addr_i[gnt_idx];
      write_q <= req_write_i[gnt_idx];
      wdata_q <= req_wdata_i[gnt_idx];
      be_q    <= req_be_i[gnt_idx];
    end
  end

  // Only the winner sees ready, and only in idle
  always_comb begin
    req_ready_o  = '0;
    resp_valid_o = '0;
    if (accept) begin
      req_ready_o[gnt_idx] = 1'b1;
    end
    if ((state_q == SOC_WAIT) && soc_resp_valid_i) begin
      resp_valid_o[core_q] = 1'b1;
    end
  end

  // Data goes to all cores; the strobe selects the owner
  assign resp_rdata_o = {`TILE_NUM_CORES{soc_resp_rdata_i}};

  assign soc_req_valid_o = (state_q == SOC_REQ);
  assign soc_req_addr_o  = addr_q;
  assign soc_req_write_o = write_q;
  assign soc_req_wdata_o = wdata_q;
  assign soc_req_be_o    = be_q;

endmodule : soc_demux_fsm

`default_nettype wire

/* source/mempool_tile.sv */
// Tile top: per-core shims, bank crossbar with TCDM banks and shared SoC port FSM
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module mempool_tile (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  tile_pkg::tile_id_t                    tile_id_i,
  // Core data requests
  input  logic            [`TILE_NUM_CORES-1:0] core_req_valid_i,
  output logic            [`TILE_NUM_CORES-1:0] core_req_ready_o,
  input  tile_pkg::addr_t [`TILE_NUM_CORES-1:0] core_req_addr_i,
  input  logic            [`TILE_NUM_CORES-1:0] core_req_write_i,
  input  tile_pkg::data_t [`TILE_NUM_CORES-1:0] core_req_wdata_i,
  input  tile_pkg::strb_t [`TILE_NUM_CORES-1:0] core_req_be_i,
  // Core data responses
  output logic            [`TILE_NUM_CORES-1:0] core_resp_valid_o,
  output tile_pkg::data_t [`TILE_NUM_CORES-1:0] core_resp_rdata_o,
  // SoC port
  output logic                                  soc_req_valid_o,
  input  logic                                  soc_req_ready_i,
  output tile_pkg::addr_t                       soc_req_addr_o,
  output logic                                  soc_req_write_o,
  output tile_pkg::data_t                       soc_req_wdata_o,
  output tile_pkg::strb_t                       soc_req_be_o,
  input  logic                                  soc_resp_valid_i,
  input  tile_pkg::data_t                       soc_resp_rdata_i
);
  import tile_pkg::*;

  // Shim outputs towards both targets
  addr_t [`TILE_NUM_CORES-1:0] fwd_addr;
  logic  [`TILE_NUM_CORES-1:0] fwd_write;
  data_t [`TILE_NUM_CORES-1:0] fwd_wdata;
  strb_t [`TILE_NUM_CORES-1:0] fwd_be;

  logic  [`TILE_NUM_CORES-1:0] bank_req_valid;
  logic  [`TILE_NUM_CORES-1:0] bank_req_ready;
  logic  [`TILE_NUM_CORES-1:0] bank_resp_valid;
  data_t [`TILE_NUM_CORES-1:0] bank_resp_rdata;

  logic  [`TILE_NUM_CORES-1:0] soc_req_valid;
  logic  [`TILE_NUM_CORES-1:0] soc_req_ready;
  logic  [`TILE_NUM_CORES-1:0] soc_resp_valid;
  data_t [`TILE_NUM_CORES-1:0] soc_resp_rdata;

  for (genvar c = 0; c < `TILE_NUM_CORES; c++) begin : gen_shims
    tcdm_shim i_shim (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .tile_id_i        (tile_id_i),
      .req_valid_i      (core_req_valid_i[c]),
      .req_ready_o      (core_req_ready_o[c]),
      .req_addr_i       (core_req_addr_i[c]),
      .req_write_i      (core_req_write_i[c]),
      .req_wdata_i      (core_req_wdata_i[c]),
      .req_be_i         (core_req_be_i[c]),
      .resp_valid_o     (core_resp_valid_o[c]),
      .resp_rdata_o     (core_resp_rdata_o[c]),
      .fwd_addr_o       (fwd_addr[c]),
      .fwd_write_o      (fwd_write[c]),
      .fwd_wdata_o      (fwd_wdata[c]),
      .fwd_be_o         (fwd_be[c]),
      .bank_valid_o     (bank_req_valid[c]),
      .bank_ready_i     (bank_req_ready[c]),
      .bank_resp_valid_i(bank_resp_valid[c]),
      .bank_resp_rdata_i(bank_resp_rdata[c]),
      .soc_valid_o      (soc_req_valid[c]),
      .soc_ready_i      (soc_req_ready[c]),
      .soc_resp_valid_i (soc_resp_valid[c]),
      .soc_resp_rdata_i (soc_resp_rdata[c])
    );
  end

  bank_xbar i_bank_xbar (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (bank_req_valid),
    .req_ready_o (bank_req_ready),
    .req_addr_i  (fwd_addr),
    .req_write_i (fwd_write),
    .req_wdata_i (fwd_wdata),
    .req_be_i    (fwd_be),
    .resp_valid_o(bank_resp_valid),
    .resp_rdata_o(bank_resp_rdata)
  );

  soc_demux_fsm i_soc_demux (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .req_valid_i     (soc_req_valid),
    .req_ready_o     (soc_req_ready),
    .req_addr_i      (fwd_addr),
    .req_write_i     (fwd_write),
    .req_wdata_i     (fwd_wdata),
    .req_be_i        (fwd_be),
    .resp_valid_o    (soc_resp_valid),
    .resp_rdata_o    (soc_resp_rdata),
    .soc_req_valid_o (soc_req_valid_o),
    .soc_req_ready_i (soc_req_ready_i),
    .soc_req_addr_o  (soc_req_addr_o),
    .soc_req_write_o (soc_req_write_o),
    .soc_req_wdata_o (soc_req_wdata_o),
    .soc_req_be_o    (soc_req_be_o),
    .soc_resp_valid_i(soc_resp_valid_i),
    .soc_resp_rdata_i(soc_resp_rdata_i)
  );

endmodule : mempool_tile

`default_nettype wire

/* tests/tb_mempool_tile.sv */
// Tile testbench with clock and reset, SoC responder, reference model, directed and random tests
`timescale 1ns/1ps
`default_nettype none

`include "tile_config.svh"

module tb_mempool_tile;
  import tile_pkg::*;

  localparam int          NC           = `TILE_NUM_CORES;
  localparam tile_id_t    TILE_ID      = 2'd1;
  localparam logic [31:0] SEED         = 32'h1376614e;
  localparam int          ROWS_USED    = 16;
  localparam int          NUM_RAND     = 48;
  // About four times the longest expected run
  localparam int          MAX_CYCLES   = 4000;
  // Longest wait for the last responses after the stimulus ends
  localparam int          DRAIN_CYCLES = 64;

  logic                  clk_i = 1'b0;
  logic                  arst_n_i;
  logic         [NC-1:0] core_req_valid_i;
  logic         [NC-1:0] core_req_ready_o;
  addr_t        [NC-1:0] core_req_addr_i;
  logic         [NC-1:0] core_req_write_i;
  data_t        [NC-1:0] core_req_wdata_i;
  strb_t        [NC-1:0] core_req_be_i;
  logic         [NC-1:0] core_resp_valid_o;
  data_t        [NC-1:0] core_resp_rdata_o;
  logic                  soc_req_valid_o;
  logic                  soc_req_ready_i;
  addr_t                 soc_req_addr_o;
  logic                  soc_req_write_o;
  data_t                 soc_req_wdata_o;
  strb_t                 soc_req_be_o;
  logic                  soc_resp_valid_i;
  data_t                 soc_resp_rdata_i;

  // Mirror of the local banks, indexed by {row, bank}
  data_t       mirror [1024];
  data_t       exp_data_q [NC][$];
  int          exp_due_q [NC][$];
  // Pending SoC port transfers as {write, be, wdata, addr}
  logic [68:0] soc_exp_q [$];

  int          cycle_cnt    = 0;
  int          checks       = 0;
  int          errors       = 0;
  bit          idle_checked = 1'b0;
  bit          soc_busy     = 1'b0;
  logic [31:0] stim_rng;

  addr_t rnd_addr  [NC][NUM_RAND];
  logic  rnd_write [NC][NUM_RAND];
  data_t rnd_wdata [NC][NUM_RAND];
  strb_t rnd_be    [NC][NUM_RAND];

  mempool_tile dut (
    .tile_id_i(TILE_ID),
    .*
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t soc_hash(input addr_t addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic data_t fill_word(input addr_t addr);
    return (addr * 32'h0001_0001) ^ 32'hA5A5_5A5A;
  endfunction

  function automatic addr_t local_addr(input bank_row_t row, input bank_id_t bank);
    return {18'd0, row, TILE_ID, bank, 2'b00};
  endfunction

  function automatic bit is_local(input addr_t addr);
    return ((addr - `TILE_TCDM_BASE) < `TILE_TCDM_SIZE) && (addr[5:4] == TILE_ID);
  endfunction

  function automatic int word_index(input addr_t addr);
    return int'({addr[13:6], addr[3:2]});
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t be);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Local writes answer zero, SoC accesses answer the responder hash
  function automatic data_t expected_rdata(input addr_t addr, input logic write);
    if (!is_local(addr)) begin
      return soc_hash(addr);
    end else if (write) begin
      return '0;
    end
    return mirror[word_index(addr)];
  endfunction

  function automatic int outstanding();
    int n;
    n = soc_exp_q.size();
    for (int c = 0; c < NC; c++) begin
      n += exp_data_q[c].size();
    end
    return n;
  endfunction

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send_req(input int c, input addr_t addr, input logic write,
                          input data_t wdata, input strb_t be);
    core_req_valid_i[c] = 1'b1;
    core_req_addr_i[c]  = addr;
    core_req_write_i[c] = write;
    core_req_wdata_i[c] = wdata;
    core_req_be_i[c]    = be;
    do begin
      @(posedge clk_i);
    end while (!core_req_ready_o[c]);
    @(negedge clk_i);
    core_req_valid_i[c] = 1'b0;
  endtask

  task automatic fill_bank(input int c);
    addr_t a;
    for (int r = 0; r < ROWS_USED; r++) begin
      a = local_addr(bank_row_t'(r), bank_id_t'(c));
      send_req(c, a, 1'b1, fill_word(a), 4'hF);
    end
  endtask

  task automatic run_random(input int c);
    for (int i = 0; i < NUM_RAND; i++) begin
      send_req(c, rnd_addr[c][i], rnd_write[c][i], rnd_wdata[c][i], rnd_be[c][i]);
    end
  endtask

  // SoC memory with random ready and response delays
  initial begin : soc_responder
    logic [31:0] rng;
    addr_t       addr;
    soc_req_ready_i  = 1'b0;
    soc_resp_valid_i = 1'b0;
    soc_resp_rdata_i = '0;
    rng = xorshift32(SEED);
    forever begin
      @(negedge clk_i);
      soc_resp_valid_i = 1'b0;
      if (soc_req_valid_o) begin
        addr = soc_req_addr_o;
        rng  = xorshift32(rng);
        repeat (rng % 4) @(negedge clk_i);
        soc_req_ready_i = 1'b1;
        @(negedge clk_i);
        soc_req_ready_i = 1'b0;
        rng = xorshift32(rng);
        repeat (rng % 4) @(negedge clk_i);
        soc_resp_valid_i = 1'b1;
        soc_resp_rdata_i = soc_hash(addr);
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  always @(posedge clk_i) begin : compare
    data_t       exp_val;
    int          due;
    addr_t       a;
    logic [68:0] s;
    if (arst_n_i) begin
      if (!idle_checked) begin
        idle_checked = 1'b1;
        checks++;
        if (core_resp_valid_o !== '0) begin
          $display("ERROR core_resp_valid_o: got %h expected %h", core_resp_valid_o, 4'h0);
          errors++;
        end
        if (soc_req_valid_o !== 1'b0) begin
          $display("ERROR soc_req_valid_o: got %h expected %h", soc_req_valid_o, 1'b0);
          errors++;
        end
      end
      for (int c = 0; c < NC; c++) begin
        if (core_resp_valid_o[c]) begin
          if (exp_data_q[c].size() == 0) begin
            $display("Core %0d got a response with no request outstanding", c);
            errors++;
          end else begin
            exp_val = exp_data_q[c].pop_front();
            due     = exp_due_q[c].pop_front();
            checks++;
            if (core_resp_rdata_o[c] !== exp_val) begin
              $display("ERROR core_resp_rdata_o[%0d]: got %h expected %h",
                       c, core_resp_rdata_o[c], exp_val);
              errors++;
            end
            if (due >= 0 && due != cycle_cnt) begin
              $display("Core %0d local response came in cycle %0d instead of cycle %0d",
                       c, cycle_cnt, due);
              errors++;
            end
          end
        end
      end
      // One SoC request outstanding at a time
      if (soc_req_valid_o && soc_busy) begin
        $display("SoC port presented a request before the previous response");
        errors++;
      end
      if (soc_req_valid_o && soc_req_ready_i) begin
        soc_busy = 1'b1;
        if (soc_exp_q.size() == 0) begin
          $display("SoC port transferred a request that no core issued");
          errors++;
        end else begin
          s = soc_exp_q.pop_front();
          checks++;
          if (soc_req_addr_o !== s[31:0]) begin
            $display("ERROR soc_req_addr_o: got %h expected %h", soc_req_addr_o, s[31:0]);
            errors++;
          end
          if (soc_req_wdata_o !== s[63:32]) begin
            $display("ERROR soc_req_wdata_o: got %h expected %h", soc_req_wdata_o, s[63:32]);
            errors++;
          end
          if (soc_req_be_o !== s[67:64] || soc_req_write_o !== s[68]) begin
            $display("ERROR soc_req_be_o/soc_req_write_o: got %h/%h expected %h/%h",
                     soc_req_be_o, soc_req_write_o, s[67:64], s[68]);
            errors++;
          end
        end
      end
      if (soc_resp_valid_i) begin
        soc_busy = 1'b0;
      end
      // Expected values are fixed at acceptance, in acceptance order
      for (int c = 0; c < NC; c++) begin
        if (core_req_valid_i[c] && core_req_ready_o[c]) begin
          a = core_req_addr_i[c];
          exp_data_q[c].push_back(expected_rdata(a, core_req_write_i[c]));
          if (is_local(a)) begin
            exp_due_q[c].push_back(cycle_cnt + 1);
            if (core_req_write_i[c]) begin
              mirror[word_index(a)] = merge_bytes(mirror[word_index(a)],
                                                  core_req_wdata_i[c], core_req_be_i[c]);
            end
          end else begin
            exp_due_q[c].push_back(-1);
            soc_exp_q.push_back({core_req_write_i[c], core_req_be_i[c],
                                 core_req_wdata_i[c], a});
          end
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    tile_id_t    t;
    int          missing;
    int          drain;
    arst_n_i         = 1'b0;
    core_req_valid_i = '0;
    core_req_addr_i  = '0;
    core_req_write_i = '0;
    core_req_wdata_i = '0;
    core_req_be_i    = '0;
    stim_rng         = SEED;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    repeat (2) @(negedge clk_i);

    // Known contents for the rows the tests use
    fork
      fill_bank(0);
      fill_bank(1);
      fill_bank(2);
      fill_bank(3);
    join

    // Partial write, then read back
    send_req(1, local_addr(8'd3, 2'd2), 1'b1, 32'hDEAD_BEEF, 4'b1010);
    send_req(1, local_addr(8'd3, 2'd2), 1'b0, '0, '0);

    // All cores on bank 1
    fork
      send_req(0, local_addr(8'd4, 2'd1), 1'b0, '0, '0);
      send_req(1, local_addr(8'd5, 2'd1), 1'b0, '0, '0);
      send_req(2, local_addr(8'd6, 2'd1), 1'b0, '0, '0);
      send_req(3, local_addr(8'd7, 2'd1), 1'b0, '0, '0);
    join

    // Remote tile slice and outside the TCDM
    send_req(2, {18'd0, 8'd9, 2'd3, 2'd0, 2'b00}, 1'b1, 32'h0BAD_CAFE, 4'b0110);
    send_req(0, {18'd0, 8'd2, 2'd0, 2'd3, 2'b00}, 1'b0, '0, '0);
    send_req(3, 32'h8000_1234, 1'b0, '0, '0);

    // Concurrent SoC reads
    fork
      send_req(0, 32'h4000_0000, 1'b0, '0, '0);
      send_req(1, 32'h4000_0010, 1'b0, '0, '0);
      send_req(2, 32'h4000_0020, 1'b1, 32'h1357_9BDF, 4'hF);
      send_req(3, 32'h4000_0030, 1'b0, '0, '0);
    join

    // Random mix over local rows, remote slices and SoC space
    for (int c = 0; c < NC; c++) begin
      for (int i = 0; i < NUM_RAND; i++) begin
        stim_rng = xorshift32(stim_rng);
        r = stim_rng;
        t = r[15:14];
        if (t == TILE_ID) begin
          t = t ^ 2'b10;
        end
        if (r[0]) begin
          rnd_addr[c][i] = local_addr({4'd0, r[11:8]}, r[13:12]);
        end else if (r[1]) begin
          rnd_addr[c][i] = {18'd0, 4'd0, r[11:8], t, r[13:12], 2'b00};
        end else begin
          rnd_addr[c][i] = {3'b001, r[31:5], 2'b00};
        end
        rnd_write[c][i] = r[2];
        rnd_be[c][i]    = r[7:4];
        stim_rng = xorshift32(stim_rng);
        rnd_wdata[c][i] = stim_rng;
      end
    end
    fork
      run_random(0);
      run_random(1);
      run_random(2);
      run_random(3);
    join

    drain = 0;
    while (outstanding() != 0 && drain < DRAIN_CYCLES) begin
      @(negedge clk_i);
      drain++;
    end
    repeat (5) @(negedge clk_i);
    missing = outstanding();
    if (missing != 0) begin
      $display("%0d expected responses never arrived", missing);
    end
    $display("Checks: %0d, errors: %0d, missing responses: %0d", checks, errors, missing);
    if (errors == 0 && missing == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tb_mempool_tile

`default_nettype wire

/* src.f */
+incdir+common
common/tile_pkg.sv
source/rr_arbiter.sv
banks/tcdm_bank.sv
banks/bank_xbar.sv
source/tcdm_shim.sv
source/soc_demux_fsm.sv
source/mempool_tile.sv
tests/tb_mempool_tile.sv

/* run.sh */
#!/bin/sh
# Compile the tile testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -f src.f --top-module tb_mempool_tile \
    --Mdir obj_dir -o tb_mempool_tile; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_mempool_tile > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -qxF '>>> PASS' "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
